//--- Makefile
LOG := sim.log

.PHONY: sim clean

sim:
	verilator --binary --timing --assert -j 0 --top-module tb_l2_mem -f l2_mem.f -o Vtb_l2_mem
	./obj_dir/Vtb_l2_mem > $(LOG) 2>&1; status=$$?; cat $(LOG); \
	if [ $$status -ne 0 ] || grep -q "FAIL: see errors above" $(LOG); then exit 1; fi

clean:
	rm -rf obj_dir $(LOG)

//--- l2_mem.f
src/l2_cfg_pkg.sv
src/l2_txn_pkg.sv
src/l2_port_decode.sv
src/l2_req_xbar.sv
src/l2_bank.sv
src/l2_rsp_router.sv
src/l2_mem_top.sv
testbench/tb_l2_mem.sv

//--- src/l2_bank.sv
// ------------------------------
// L2 bank: byte-enabled SRAM and
// its tagged response register
// ------------------------------
`timescale 1ns/1ps
`default_nettype none

module l2_bank (
  input  logic                   clk_i,
  input  logic                   rst_n_i,
  input  logic                   req_valid_i,
  input  logic                   req_write_i,
  input  l2_txn_pkg::bank_addr_t req_addr_i,
  input  l2_txn_pkg::data_t      req_wdata_i,
  input  l2_txn_pkg::strb_t      req_strb_i,
  input  l2_txn_pkg::port_idx_t  req_src_i,
  output logic                   req_ready_o,
  output logic                   rsp_valid_o,
  output l2_txn_pkg::data_t      rsp_rdata_o,
  output l2_txn_pkg::port_idx_t  rsp_src_o,
  input  logic                   rsp_ready_i
);

  import l2_cfg_pkg::*;
  import l2_txn_pkg::*;

  localparam int unsigned LaneWidth = DataWidth / BeWidth;

  data_t     mem_q [BankNumWords];
  logic      rsp_valid_q;
  data_t     rsp_rdata_q;
  port_idx_t rsp_src_q;
  logic      req_fire;

  // Free slot or the waiting response leaves this cycle
  assign req_ready_o = !rsp_valid_q || rsp_ready_i;
  assign req_fire    = req_valid_i && req_ready_o;

  always_ff @(posedge clk_i) begin
    if (req_fire && req_write_i) begin
      for (int i = 0; i < BeWidth; i++) begin
        if (req_strb_i[i]) begin
          mem_q[req_addr_i][i*LaneWidth +: LaneWidth] <= req_wdata_i[i*LaneWidth +: LaneWidth];
        end
      end
    end
  end

  // Writes return the old word as well
  always_ff @(posedge clk_i) begin
    if (req_fire) begin
      rsp_rdata_q <= mem_q[req_addr_i];
      rsp_src_q   <= req_src_i;  // Origin tag for the router
    end
  end

  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      rsp_valid_q <= 1'b0;
    end else if (req_fire) begin
      rsp_valid_q <= 1'b1;
    end else if (rsp_ready_i) begin
      rsp_valid_q <= 1'b0;
    end
  end

  assign rsp_valid_o = rsp_valid_q;
  assign rsp_rdata_o = rsp_rdata_q;
  assign rsp_src_o   = rsp_src_q;

  // A stalled request from the crossbar keeps its grant and payload
  a_req_stable: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    req_valid_i && !req_ready_o |=>
      req_valid_i && $stable(req_addr_i) && $stable(req_write_i)
      && $stable(req_wdata_i) && $stable(req_strb_i) && $stable(req_src_i))
    else $error("Bank request changed while stalled");

endmodule : l2_bank

`default_nettype wire

//--- src/l2_cfg_pkg.sv
// ------------------------------
// Sizing of the L2 memory, its
// banks and its request ports
// ------------------------------
`default_nettype none

package l2_cfg_pkg;

  localparam int unsigned NumPorts     = 2;   // Request ports sharing L2
  localparam int unsigned NumBanks     = 4;   // Word-interleaved banks
  localparam int unsigned DataWidth    = 32;
  localparam int unsigned BeWidth      = DataWidth / 8;
  localparam int unsigned BankNumWords = 64;  // Depth of one bank

  // Byte address is | bank word | bank index | byte offset |
  localparam int unsigned ByteOffWidth  = $clog2(BeWidth);
  localparam int unsigned BankIdxWidth  = $clog2(NumBanks);
  localparam int unsigned BankAddrWidth = $clog2(BankNumWords);
  localparam int unsigned L2AddrWidth   = BankAddrWidth + BankIdxWidth + ByteOffWidth;

  // Origin tag stays one bit wide even for a single port
  localparam int unsigned PortIdxWidth = (NumPorts > 1) ? $clog2(NumPorts) : 1;

endpackage : l2_cfg_pkg

`default_nettype wire

//--- src/l2_mem_top.sv
// ------------------------------
// Banked L2 memory top level
// ------------------------------
`timescale 1ns/1ps
`default_nettype none

module l2_mem_top (
  input  logic                                            clk_i,
  input  logic                                            rst_n_i,
  // Request side of each port
  input  logic                 [l2_cfg_pkg::NumPorts-1:0] q_valid_i,
  input  l2_txn_pkg::l2_addr_t [l2_cfg_pkg::NumPorts-1:0] q_addr_i,
  input  logic                 [l2_cfg_pkg::NumPorts-1:0] q_write_i,
  input  l2_txn_pkg::data_t    [l2_cfg_pkg::NumPorts-1:0] q_wdata_i,
  input  l2_txn_pkg::strb_t    [l2_cfg_pkg::NumPorts-1:0] q_strb_i,
  output logic                 [l2_cfg_pkg::NumPorts-1:0] q_ready_o,
  // Response side of each port
  output logic                 [l2_cfg_pkg::NumPorts-1:0] p_valid_o,
  output l2_txn_pkg::data_t    [l2_cfg_pkg::NumPorts-1:0] p_rdata_o,
  input  logic                 [l2_cfg_pkg::NumPorts-1:0] p_ready_i
);

  import l2_cfg_pkg::*;
  import l2_txn_pkg::*;

  // Decoders to crossbar
  logic       [NumPorts-1:0] req_valid, req_write, req_ready;
  bank_idx_t  [NumPorts-1:0] req_bank;
  bank_addr_t [NumPorts-1:0] req_addr;
  data_t      [NumPorts-1:0] req_wdata;
  strb_t      [NumPorts-1:0] req_strb;
  // Crossbar to banks
  logic       [NumBanks-1:0] bank_valid, bank_write, bank_ready;
  bank_addr_t [NumBanks-1:0] bank_addr;
  data_t      [NumBanks-1:0] bank_wdata;
  strb_t      [NumBanks-1:0] bank_strb;
  port_idx_t  [NumBanks-1:0] bank_src;
  // Banks to router and router to decoders
  logic       [NumBanks-1:0] rsp_valid, rsp_ready;
  data_t      [NumBanks-1:0] rsp_rdata;
  port_idx_t  [NumBanks-1:0] rsp_src;
  logic       [NumPorts-1:0] port_rsp_valid;
  data_t      [NumPorts-1:0] port_rsp_rdata;

  for (genvar p = 0; p < NumPorts; p++) begin : gen_decode
    l2_port_decode u_l2_port_decode (
      .clk_i      (clk_i            ),
      .rst_n_i    (rst_n_i          ),
      .q_valid_i  (q_valid_i[p]     ),
      .q_write_i  (q_write_i[p]     ),
      .q_addr_i   (q_addr_i[p]      ),
      .q_wdata_i  (q_wdata_i[p]     ),
      .q_strb_i   (q_strb_i[p]      ),
      .q_ready_o  (q_ready_o[p]     ),
      .req_valid_o(req_valid[p]     ),
      .req_write_o(req_write[p]     ),
      .req_bank_o (req_bank[p]      ),
      .req_addr_o (req_addr[p]      ),
      .req_wdata_o(req_wdata[p]     ),
      .req_strb_o (req_strb[p]      ),
      .req_ready_i(req_ready[p]     ),
      .rsp_valid_i(port_rsp_valid[p]),
      .rsp_rdata_i(port_rsp_rdata[p]),
      .p_valid_o  (p_valid_o[p]     ),
      .p_rdata_o  (p_rdata_o[p]     ),
      .p_ready_i  (p_ready_i[p]     )
    );
  end

  l2_req_xbar u_l2_req_xbar (
    .clk_i       (clk_i     ),
    .rst_n_i     (rst_n_i   ),
    .req_valid_i (req_valid ),
    .req_write_i (req_write ),
    .req_bank_i  (req_bank  ),
    .req_addr_i  (req_addr  ),
    .req_wdata_i (req_wdata ),
    .req_strb_i  (req_strb  ),
    .req_ready_o (req_ready ),
    .bank_valid_o(bank_valid),
    .bank_addr_o (bank_addr ),
    .bank_write_o(bank_write),
    .bank_wdata_o(bank_wdata),
    .bank_strb_o (bank_strb ),
    .bank_src_o  (bank_src  ),
    .bank_ready_i(bank_ready)
  );

  for (genvar b = 0; b < NumBanks; b++) begin : gen_bank
    l2_bank u_l2_bank (
      .clk_i      (clk_i        ),
      .rst_n_i    (rst_n_i      ),
      .req_valid_i(bank_valid[b]),
      .req_write_i(bank_write[b]),
      .req_addr_i (bank_addr[b] ),
      .req_wdata_i(bank_wdata[b]),
      .req_strb_i (bank_strb[b] ),
      .req_src_i  (bank_src[b]  ),
      .req_ready_o(bank_ready[b]),
      .rsp_valid_o(rsp_valid[b] ),
      .rsp_rdata_o(rsp_rdata[b] ),
      .rsp_src_o  (rsp_src[b]   ),
      .rsp_ready_i(rsp_ready[b] )
    );
  end

  l2_rsp_router u_l2_rsp_router (
    .rsp_valid_i     (rsp_valid     ),
    .rsp_rdata_i     (rsp_rdata     ),
    .rsp_src_i       (rsp_src       ),
    .rsp_ready_o     (rsp_ready     ),
    .port_rsp_valid_o(port_rsp_valid),
    .port_rsp_rdata_o(port_rsp_rdata),
    .port_rsp_ready_i(p_ready_i     )
  );

endmodule : l2_mem_top

`default_nettype wire

//--- src/l2_port_decode.sv
// ------------------------------
// Port decoder: one-outstanding
// throttle and bank selection
// ------------------------------
`timescale 1ns/1ps
`default_nettype none

module l2_port_decode (
  input  logic                   clk_i,
  input  logic                   rst_n_i,
  // Request from the port
  input  logic                   q_valid_i,
  input  logic                   q_write_i,
  input  l2_txn_pkg::l2_addr_t   q_addr_i,
  input  l2_txn_pkg::data_t      q_wdata_i,
  input  l2_txn_pkg::strb_t      q_strb_i,
  output logic                   q_ready_o,
  // Request toward the crossbar
  output logic                   req_valid_o,
  output logic                   req_write_o,
  output l2_txn_pkg::bank_idx_t  req_bank_o,
  output l2_txn_pkg::bank_addr_t req_addr_o,
  output l2_txn_pkg::data_t      req_wdata_o,
  output l2_txn_pkg::strb_t      req_strb_o,
  input  logic                   req_ready_i,
  // Routed bank response
  input  logic                   rsp_valid_i,
  input  l2_txn_pkg::data_t      rsp_rdata_i,
  // Response to the port
  output logic                   p_valid_o,
  output l2_txn_pkg::data_t      p_rdata_o,
  input  logic                   p_ready_i
);

  import l2_cfg_pkg::*;
  import l2_txn_pkg::*;

  decode_state_e state_q, state_d;

  logic q_fire;
  logic p_fire;

  // Requests pass straight through while no transaction is open
  assign req_valid_o = q_valid_i && (state_q == IDLE);
  assign q_ready_o   = (state_q == IDLE) && (!q_valid_i || req_ready_i);

  assign q_fire = q_valid_i && q_ready_o;
  assign p_fire = p_valid_o && p_ready_i;

  // Bank index sits right above the byte offset for interleaving
  assign req_bank_o  = q_addr_i[ByteOffWidth +: BankIdxWidth];
  assign req_addr_o  = q_addr_i[ByteOffWidth + BankIdxWidth +: BankAddrWidth];
  assign req_write_o = q_write_i;
  assign req_wdata_o = q_wdata_i;
  assign req_strb_o  = q_strb_i;

  assign p_valid_o = rsp_valid_i;  // Only this port's response gets here
  assign p_rdata_o = rsp_rdata_i;

  always_comb begin
    state_d = state_q;
    case (state_q)
      IDLE:    if (q_fire) state_d = PENDING;
      PENDING: if (p_fire) state_d = IDLE;
      default: state_d = IDLE;
    endcase
  end

  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      state_q <= IDLE;
    end else begin
      state_q <= state_d;
    end
  end

  // The router only delivers what this port asked for
  a_no_rsp_in_idle: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    rsp_valid_i |-> state_q == PENDING)
    else $error("Response on a port with no outstanding request");

  // Bank answers on the edge after its request transfer
  a_rsp_next_cycle: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    q_fire |=> p_valid_o)
    else $error("Response did not follow its request by one cycle");

endmodule : l2_port_decode

`default_nettype wire

//--- src/l2_req_xbar.sv
// ------------------------------
// Request crossbar with a locked
// round-robin arbiter per bank
// ------------------------------
`timescale 1ns/1ps
`default_nettype none

module l2_req_xbar (
  input  logic                                                    clk_i,
  input  logic                                                    rst_n_i,
  // Per-port requests
  input  logic                   [l2_cfg_pkg::NumPorts-1:0]       req_valid_i,
  input  logic                   [l2_cfg_pkg::NumPorts-1:0]       req_write_i,
  input  l2_txn_pkg::bank_idx_t  [l2_cfg_pkg::NumPorts-1:0]       req_bank_i,
  input  l2_txn_pkg::bank_addr_t [l2_cfg_pkg::NumPorts-1:0]       req_addr_i,
  input  l2_txn_pkg::data_t      [l2_cfg_pkg::NumPorts-1:0]       req_wdata_i,
  input  l2_txn_pkg::strb_t      [l2_cfg_pkg::NumPorts-1:0]       req_strb_i,
  output logic                   [l2_cfg_pkg::NumPorts-1:0]       req_ready_o,
  // Per-bank requests
  output logic                   [l2_cfg_pkg::NumBanks-1:0]       bank_valid_o,
  output l2_txn_pkg::bank_addr_t [l2_cfg_pkg::NumBanks-1:0]       bank_addr_o,
  output logic                   [l2_cfg_pkg::NumBanks-1:0]       bank_write_o,
  output l2_txn_pkg::data_t      [l2_cfg_pkg::NumBanks-1:0]       bank_wdata_o,
  output l2_txn_pkg::strb_t      [l2_cfg_pkg::NumBanks-1:0]       bank_strb_o,
  output l2_txn_pkg::port_idx_t  [l2_cfg_pkg::NumBanks-1:0]       bank_src_o,
  input  logic                   [l2_cfg_pkg::NumBanks-1:0]       bank_ready_i
);

  import l2_cfg_pkg::*;
  import l2_txn_pkg::*;

  for (genvar b = 0; b < NumBanks; b++) begin : gen_bank_arb
    logic [NumPorts-1:0] bank_req;  // Ports aiming at this bank
    port_idx_t           gnt;
    port_idx_t           rr_q;      // Highest-priority port
    logic                lock_q;
    port_idx_t           lock_src_q;

    always_comb begin
      for (int p = 0; p < NumPorts; p++) begin
        bank_req[p] = req_valid_i[p] && (req_bank_i[p] == bank_idx_t'(b));
      end
    end

    always_comb begin : rr_pick
      logic found;
      found = 1'b0;
      gnt   = rr_q;
      if (lock_q) begin
        gnt   = lock_src_q;  // Stalled grant holds until it transfers
        found = 1'b1;
      end
      for (int p = 0; p < NumPorts; p++) begin
        if (!found && bank_req[p] && (port_idx_t'(p) >= rr_q)) begin
          gnt   = port_idx_t'(p);
          found = 1'b1;
        end
      end
      // Wrap around below the pointer
      for (int p = 0; p < NumPorts; p++) begin
        if (!found && bank_req[p]) begin
          gnt   = port_idx_t'(p);
          found = 1'b1;
        end
      end
    end

    assign bank_valid_o[b] = |bank_req;
    assign bank_src_o[b]   = gnt;
    assign bank_addr_o[b]  = req_addr_i[gnt];
    assign bank_write_o[b] = req_write_i[gnt];
    assign bank_wdata_o[b] = req_wdata_i[gnt];
    assign bank_strb_o[b]  = req_strb_i[gnt];

    always_ff @(posedge clk_i or negedge rst_n_i) begin
      if (!rst_n_i) begin
        rr_q       <= '0;
        lock_q     <= 1'b0;
        lock_src_q <= '0;
      end else if (bank_valid_o[b]) begin
        if (bank_ready_i[b]) begin
          lock_q <= 1'b0;
          rr_q   <= (gnt == port_idx_t'(NumPorts - 1)) ? '0 : port_idx_t'(gnt + 1'b1);
        end else begin
          lock_q     <= 1'b1;
          lock_src_q <= gnt;
        end
      end
    end

    // A locked port must keep its request up
    a_lock_held: assert property (@(posedge clk_i) disable iff (!rst_n_i)
      lock_q |-> bank_req[lock_src_q])
      else $error("Locked request on bank %0d dropped before transfer", b);
  end

  for (genvar p = 0; p < NumPorts; p++) begin : gen_port_ready
    logic [NumBanks-1:0] port_gnt;

    always_comb begin
      for (int b = 0; b < NumBanks; b++) begin
        port_gnt[b] = bank_valid_o[b] && (bank_src_o[b] == port_idx_t'(p));
      end
    end

    assign req_ready_o[p] = |(port_gnt & bank_ready_i);

    a_one_bank: assert property (@(posedge clk_i) disable iff (!rst_n_i)
      $onehot0(port_gnt))
      else $error("Port %0d granted by more than one bank", p);
  end

endmodule : l2_req_xbar

`default_nettype wire

//--- src/l2_rsp_router.sv
// ------------------------------
// Response router from banks
// back to the requesting ports
// ------------------------------
`timescale 1ns/1ps
`default_nettype none

module l2_rsp_router (
  // Per-bank responses
  input  logic                  [l2_cfg_pkg::NumBanks-1:0] rsp_valid_i,
  input  l2_txn_pkg::data_t     [l2_cfg_pkg::NumBanks-1:0] rsp_rdata_i,
  input  l2_txn_pkg::port_idx_t [l2_cfg_pkg::NumBanks-1:0] rsp_src_i,
  output logic                  [l2_cfg_pkg::NumBanks-1:0] rsp_ready_o,
  // Per-port responses
  output logic                  [l2_cfg_pkg::NumPorts-1:0] port_rsp_valid_o,
  output l2_txn_pkg::data_t     [l2_cfg_pkg::NumPorts-1:0] port_rsp_rdata_o,
  input  logic                  [l2_cfg_pkg::NumPorts-1:0] port_rsp_ready_i
);

  import l2_cfg_pkg::*;
  import l2_txn_pkg::*;

  logic [NumPorts-1:0][NumBanks-1:0] hit;  // Bank b answers port p

  always_comb begin
    for (int p = 0; p < NumPorts; p++) begin
      for (int b = 0; b < NumBanks; b++) begin
        hit[p][b] = rsp_valid_i[b] && (rsp_src_i[b] == port_idx_t'(p));
      end
    end
  end

  always_comb begin
    port_rsp_rdata_o = '0;
    for (int p = 0; p < NumPorts; p++) begin
      port_rsp_valid_o[p] = |hit[p];
      for (int b = 0; b < NumBanks; b++) begin
        if (hit[p][b]) port_rsp_rdata_o[p] = rsp_rdata_i[b];
      end
    end
  end

  // Each bank sees the ready of the port its tag names
  for (genvar b = 0; b < NumBanks; b++) begin : gen_ready
    assign rsp_ready_o[b] = port_rsp_ready_i[rsp_src_i[b]];
  end

  // One outstanding request per port means one bank per port
  always_comb begin
    for (int p = 0; p < NumPorts; p++) begin
      a_one_src: assert final ($onehot0(hit[p]))
        else $error("Two banks answer port %0d at once", p);
    end
  end

endmodule : l2_rsp_router

`default_nettype wire

//--- src/l2_txn_pkg.sv
// ------------------------------
// Transaction field types and
// the decoder state encoding
// ------------------------------
`default_nettype none

package l2_txn_pkg;

  import l2_cfg_pkg::*;

  // Byte offset inside the whole L2 region
  typedef logic [L2AddrWidth-1:0] l2_addr_t;

  typedef logic [DataWidth-1:0] data_t;
  typedef logic [BeWidth-1:0]   strb_t;   // One enable per byte lane

  // Bank selection and the word address left after it
  typedef logic [BankIdxWidth-1:0]  bank_idx_t;
  typedef logic [BankAddrWidth-1:0] bank_addr_t;

  // Which port a request came from
  typedef logic [PortIdxWidth-1:0] port_idx_t;

  // One outstanding transaction per port
  typedef enum logic {
    IDLE    = 1'b0,  // Free to accept a request
    PENDING = 1'b1   // Waiting for the response transfer
  } decode_state_e;

endpackage : l2_txn_pkg

`default_nettype wire

//--- testbench/tb_l2_mem.sv
// ------------------------------
// Testbench for the banked L2
// memory with a byte-level model
// ------------------------------
`timescale 1ns/1ps
`default_nettype none

module tb_l2_mem;

  import l2_cfg_pkg::*;
  import l2_txn_pkg::*;

  localparam int WaitLimit = 200;                   // Cycles before a wait gives up
  localparam int NumWords  = NumBanks * BankNumWords;
  localparam int RandomOps = 60;                    // Per port in the mixed phase

  logic                    clk_i;
  logic                    rst_n_i;
  logic     [NumPorts-1:0] q_valid_i;
  l2_addr_t [NumPorts-1:0] q_addr_i;
  logic     [NumPorts-1:0] q_write_i;
  data_t    [NumPorts-1:0] q_wdata_i;
  strb_t    [NumPorts-1:0] q_strb_i;
  logic     [NumPorts-1:0] q_ready_o;
  logic     [NumPorts-1:0] p_valid_o;
  data_t    [NumPorts-1:0] p_rdata_o;
  logic     [NumPorts-1:0] p_ready_i;

  logic [7:0]          ref_mem [NumWords*BeWidth];  // Byte-level reference
  data_t               exp_rdata [NumPorts];
  logic [NumPorts-1:0] chk_rd;                      // Response carries read data
  logic                idle_chk;
  int                  seed    = 32'he76b1fe4;
  int                  req_cnt = 0;
  int                  rsp_cnt = 0;

  l2_mem_top u_l2_mem_top (
    .clk_i    (clk_i    ),
    .rst_n_i  (rst_n_i  ),
    .q_valid_i(q_valid_i),
    .q_addr_i (q_addr_i ),
    .q_write_i(q_write_i),
    .q_wdata_i(q_wdata_i),
    .q_strb_i (q_strb_i ),
    .q_ready_o(q_ready_o),
    .p_valid_o(p_valid_o),
    .p_rdata_o(p_rdata_o),
    .p_ready_i(p_ready_i)
  );

  always #10 clk_i = !clk_i;

  task automatic fail_check(input string msg);
    $display("CHECK FAILED at %0t ns: %s", $time, msg);
    $display("FAIL: see errors above");
    $fatal(1, "Stopped at the first error");
  endtask

  task automatic stop_on_timeout(input string msg);
    $display("%s", msg);
    $display("FAIL: see errors above");
    $fatal(1, "Stopped on a timeout");
  endtask

  function automatic data_t read_model(input int word);
    data_t d;
    for (int i = 0; i < BeWidth; i++) begin
      d[8*i +: 8] = ref_mem[word*BeWidth + i];
    end
    return d;
  endfunction

  function automatic void write_model(input int word, input data_t wdata, input strb_t strb);
    for (int i = 0; i < BeWidth; i++) begin
      if (strb[i]) ref_mem[word*BeWidth + i] = wdata[8*i +: 8];
    end
  endfunction

  // Distinct word for every L2 address
  function automatic data_t fill_word(input int word);
    return data_t'(word * 32'h9e37_79b1) ^ 32'h5a0f_c3a5;
  endfunction

  // One full transaction on port p that starts and ends 2 ns after an edge
  task automatic access_port(input int p, input logic wr, input int word,
                             input data_t wdata, input strb_t strb);
    int   waited;
    logic done;
    exp_rdata[p] = read_model(word);
    chk_rd[p]    = !wr;
    if (wr) write_model(word, wdata, strb);
    q_valid_i[p] = 1'b1;
    q_write_i[p] = wr;
    q_addr_i[p]  = l2_addr_t'(word * BeWidth);
    q_wdata_i[p] = wdata;
    q_strb_i[p]  = strb;
    waited = 0;
    done   = 1'b0;
    while (!done) begin
      @(negedge clk_i);
      done   = q_ready_o[p];
      waited = waited + 1;
      if (!done && waited >= WaitLimit) begin
        stop_on_timeout($sformatf("Port %0d timed out waiting for q_ready_o", p));
      end
    end
    @(posedge clk_i);
    #2;
    q_valid_i[p] = 1'b0;
    waited = 0;
    done   = 1'b0;
    while (!done) begin
      @(negedge clk_i);
      done   = p_valid_o[p] && p_ready_i[p];
      waited = waited + 1;
      if (!done && waited >= WaitLimit) begin
        stop_on_timeout($sformatf("Port %0d timed out waiting for its response", p));
      end
    end
    @(posedge clk_i);
    #2;
  endtask

  // Port p only touches words whose lowest bank-word bit equals p
  task automatic run_mixed(input int p);
    int    r;
    int    word;
    data_t wdata;
    for (int n = 0; n < RandomOps; n++) begin
      r     = $random(seed);
      wdata = $random(seed);
      word  = ((r >> 3) & (BankNumWords / 2 - 1)) * 2 * NumBanks
            + p * NumBanks + (r & (NumBanks - 1));
      access_port(p, r[8], word, wdata, strb_t'(r >> 9));
    end
  endtask

  // Random back-pressure on the response side
  initial begin : ready_gen
    int r;
    p_ready_i = '0;
    forever begin
      @(posedge clk_i);
      #2;
      r = $random(seed);
      for (int p = 0; p < NumPorts; p++) begin
        p_ready_i[p] = r[2*p] | r[2*p+1];  // Ready about 3 cycles in 4
      end
    end
  end

  always @(negedge clk_i) begin
    if (rst_n_i) begin
      req_cnt = req_cnt + $countones(q_valid_i & q_ready_o);
      rsp_cnt = rsp_cnt + $countones(p_valid_o & p_ready_i);
    end
  end

  for (genvar p = 0; p < NumPorts; p++) begin : gen_port_chk
    a_idle_after_rst: assert property (@(posedge clk_i)
      idle_chk |-> !p_valid_o[p] && q_ready_o[p])
      else fail_check($sformatf("port %0d not idle after reset", p));

    a_read_data: assert property (@(posedge clk_i) disable iff (!rst_n_i)
      p_valid_o[p] && p_ready_i[p] && chk_rd[p] |-> p_rdata_o[p] == exp_rdata[p])
      else fail_check($sformatf("port %0d read 0x%08h, model holds 0x%08h",
                                p, p_rdata_o[p], exp_rdata[p]));

    a_rsp_delay: assert property (@(posedge clk_i) disable iff (!rst_n_i)
      q_valid_i[p] && q_ready_o[p] |=> p_valid_o[p])
      else fail_check($sformatf("port %0d response late after its request", p));

    a_rsp_origin: assert property (@(posedge clk_i) disable iff (!rst_n_i)
      $rose(p_valid_o[p]) |-> $past(q_valid_i[p] && q_ready_o[p]))
      else fail_check($sformatf("port %0d response without a request one cycle before", p));

    a_rsp_hold: assert property (@(posedge clk_i) disable iff (!rst_n_i)
      p_valid_o[p] && !p_ready_i[p] |=>
        p_valid_o[p] && (p_rdata_o[p] === $past(p_rdata_o[p])))
      else fail_check($sformatf("port %0d response changed while stalled", p));

    a_busy: assert property (@(posedge clk_i) disable iff (!rst_n_i)
      p_valid_o[p] |-> !q_ready_o[p])  // One outstanding transaction
      else fail_check($sformatf("port %0d accepts a request with a response open", p));
  end

  initial begin : main
    data_t wdata;
    int    word;
    int    r;
    clk_i     = 1'b0;
    rst_n_i   = 1'b0;
    idle_chk  = 1'b0;
    chk_rd    = '0;
    q_valid_i = '0;
    q_addr_i  = '0;
    q_write_i = '0;
    q_wdata_i = '0;
    q_strb_i  = '0;
    repeat (10) @(posedge clk_i);
    #2;
    rst_n_i  = 1'b1;
    idle_chk = 1'b1;  // Quiet cycles before the first request
    repeat (3) @(posedge clk_i);
    #2;
    idle_chk = 1'b0;

    // Port 0 fills every bank and port 1 reads the same words back
    for (int w = 0; w < NumWords; w++) begin
      access_port(0, 1'b1, w, fill_word(w), '1);
    end
    for (int w = 0; w < NumWords; w++) begin
      access_port(1, 1'b0, w, '0, '0);
    end

    // Strobed writes merged into filled words
    for (int k = 0; k < 32; k++) begin
      r     = $random(seed);
      word  = r & (NumWords - 1);
      wdata = $random(seed);
      access_port(1, 1'b1, word, wdata, strb_t'(r >> 8));
      access_port(0, 1'b0, word, '0, '0);
    end

    // Both ports at once and often on the same bank
    fork
      run_mixed(0);
      run_mixed(1);
    join

    if (rsp_cnt != req_cnt) begin
      fail_check($sformatf("%0d requests but %0d responses", req_cnt, rsp_cnt));
    end else begin
      $display("PASS: all tests");
      $finish;
    end
  end

endmodule : tb_l2_mem

`default_nettype wire
